//--- Makefile
TOP = tb_pool_subsystem

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pool_subsystem.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f pool_subsystem.f

clean:
	rm -rf obj_dir sim.log

//--- pool_subsystem.f
rtl/cnn_pkg.sv
rtl/pool_unit.sv
rtl/result_writer.sv
rtl/host_reader.sv
rtl/mem_arbiter.sv
rtl/fmap_ram.sv
rtl/pool_subsystem.sv
tb/tb_pool_subsystem.sv

//--- rtl/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // pixel and lane geometry
    localparam int PIX_W       = 8;
    localparam int IN_LANES    = 24;    // pixels per input column
    localparam int OUT_LANES   = 12;    // pixels per pooled word
    localparam int SMALL_LANES = 6;     // lanes kept when layer1 is low

    // column count input width
    localparam int COL_W = 16;

    // one unsigned pixel
    typedef logic [PIX_W-1:0] pix_t;

    // one column from the conv engine, lane 0 in the low byte
    typedef pix_t [IN_LANES-1:0] in_col_t;

    // pooled word as stored in the feature-map RAM
    typedef pix_t [OUT_LANES-1:0] pool_word_t;

endpackage

`default_nettype wire

//--- rtl/fmap_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fmap_ram import cnn_pkg::*; #(
    parameter int DEPTH  = 64,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              ram_en,
    input  logic              ram_we,
    input  logic [ADDR_W-1:0] ram_addr,
    input  pool_word_t        ram_wdata,
    output pool_word_t        ram_rdata
);

    pool_word_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (ram_en)
        begin
            if (ram_we)
                mem[ram_addr] <= ram_wdata;
            else
                ram_rdata <= mem[ram_addr];    // one cycle read latency
        end
    end

endmodule

`default_nettype wire

//--- rtl/host_reader.sv
`timescale 1ns/1ps
`default_nettype none

module host_reader import cnn_pkg::*; #(
    parameter int DEPTH  = 64,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              r_gnt,
    output logic              r_req,
    output logic [ADDR_W-1:0] r_addr,
    input  pool_word_t        ram_rdata,
    output logic              rd_valid,
    output pool_word_t        rd_data
);

    logic rd_flag;  // ram_rdata valid this cycle

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            r_req    <= 1'b0;
            rd_flag  <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            if (rd_req)
                r_req <= 1'b1;
            else if (r_gnt)
                r_req <= 1'b0;
            rd_flag  <= r_req & r_gnt;
            rd_valid <= rd_flag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_req)
            r_addr <= rd_addr;
        if (rd_flag)
            rd_data <= ram_rdata;
    end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cnn_pkg::*; #(
    parameter int DEPTH  = 64,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              w_req,
    input  logic              r_req,
    input  logic [ADDR_W-1:0] w_addr,
    input  logic [ADDR_W-1:0] r_addr,
    input  pool_word_t        w_data,
    output logic              w_gnt,
    output logic              r_gnt,
    output logic              ram_en,
    output logic              ram_we,
    output logic [ADDR_W-1:0] ram_addr,
    output pool_word_t        ram_wdata
);

    logic [1:0] wait_cnt;   // consecutive refused read cycles

    // writer always wins
    assign w_gnt     = w_req;
    assign r_gnt     = r_req & ~w_req;
    assign ram_en    = w_req | r_req;
    assign ram_we    = w_req;
    assign ram_addr  = w_req ? w_addr : r_addr;
    assign ram_wdata = w_data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wait_cnt <= '0;
        else if (r_req && !r_gnt)
            wait_cnt <= (wait_cnt == 2'd3) ? wait_cnt : wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    read_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
        (r_req && !r_gnt) |-> (wait_cnt < 2'd2));

    one_grant_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(w_gnt && r_gnt));

endmodule

`default_nettype wire

//--- rtl/pool_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module pool_subsystem import cnn_pkg::*; #(
    parameter int DEPTH  = 64,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pool_en,
    input  logic              layer1,
    input  logic [COL_W-1:0]  col,
    input  logic              valid_in,
    input  in_col_t           data_in,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_valid,
    output pool_word_t        rd_data,
    output logic              pool_end,
    output logic [ADDR_W-1:0] wr_addr
);

    // pool unit to writer
    logic              res_valid;
    pool_word_t        res_data;

    // requesters to arbiter
    logic              w_req;
    logic              w_gnt;
    logic [ADDR_W-1:0] w_addr;
    pool_word_t        w_data;
    logic              r_req;
    logic              r_gnt;
    logic [ADDR_W-1:0] r_addr;

    // single RAM port
    logic              ram_en;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    pool_word_t        ram_wdata;
    pool_word_t        ram_rdata;

    pool_unit i_pool_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .pool_en   (pool_en),
        .layer1    (layer1),
        .valid_in  (valid_in),
        .col       (col),
        .data_in   (data_in),
        .res_valid (res_valid),
        .res_data  (res_data),
        .pool_end  (pool_end)
    );

    result_writer #(.DEPTH(DEPTH)) i_result_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_data  (res_data),
        .w_gnt     (w_gnt),
        .w_req     (w_req),
        .w_addr    (w_addr),
        .w_data    (w_data),
        .wr_addr   (wr_addr)
    );

    host_reader #(.DEPTH(DEPTH)) i_host_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .r_gnt     (r_gnt),
        .r_req     (r_req),
        .r_addr    (r_addr),
        .ram_rdata (ram_rdata),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    mem_arbiter #(.DEPTH(DEPTH)) i_mem_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_req     (w_req),
        .r_req     (r_req),
        .w_addr    (w_addr),
        .r_addr    (r_addr),
        .w_data    (w_data),
        .w_gnt     (w_gnt),
        .r_gnt     (r_gnt),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    fmap_ram #(.DEPTH(DEPTH)) i_fmap_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/pool_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pool_unit import cnn_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pool_en,
    input  logic             layer1,
    input  logic             valid_in,
    input  logic [COL_W-1:0] col,
    input  in_col_t          data_in,
    output logic             res_valid,
    output pool_word_t       res_data,
    output logic             pool_end
);

    function automatic pix_t max_pix(input pix_t a, input pix_t b);
        return (a < b) ? b : a;
    endfunction

    logic             valid_ff1;
    logic             valid_ff2;
    in_col_t          data_ff1;
    in_col_t          data_ff2;
    logic             start;        // rising edge of valid_in
    logic             nopool_end;   // frame end in bypass mode

    logic             frame_act;
    logic [COL_W-1:0] col_cnt;
    logic             v_odd;        // vmax holds an odd column
    logic             v_last;       // vmax holds the last column

    pool_word_t       vmax;
    pool_word_t       cur;
    pool_word_t       prev;
    logic             pair_rdy;
    logic             last_s4;

    pool_word_t       res_word;
    logic             res_valid_p;
    logic             last_s5;
    logic             pool_end_p;

    // input registers and edge detect
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_ff1  <= 1'b0;
            valid_ff2  <= 1'b0;
            start      <= 1'b0;
            nopool_end <= 1'b0;
        end
        else
        begin
            valid_ff1  <= valid_in;
            valid_ff2  <= valid_ff1;
            start      <= valid_in & ~valid_ff1;
            nopool_end <= ~valid_in & valid_ff1;
        end
    end

    always_ff @(posedge clk)
    begin
        data_ff1 <= data_in;
        data_ff2 <= data_ff1;
    end

    // column counter, aligned with data_ff2
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            frame_act <= 1'b0;
            col_cnt   <= '0;
            v_odd     <= 1'b0;
            v_last    <= 1'b0;
        end
        else
        begin
            v_odd  <= 1'b0;
            v_last <= 1'b0;
            if (start)
            begin
                frame_act <= 1'b1;
                col_cnt   <= '0;
            end
            else if (frame_act && valid_ff2)
            begin
                v_odd <= col_cnt[0];
                if (col_cnt == col - 1'b1)
                begin
                    // last column of the frame
                    col_cnt   <= '0;
                    frame_act <= 1'b0;
                    v_last    <= 1'b1;
                end
                else
                begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // vertical pairs, column hold, horizontal max
    always_ff @(posedge clk)
    begin
        for (int m = 0; m < OUT_LANES; m++)
        begin
            vmax[m] <= max_pix(data_ff2[2*m], data_ff2[2*m+1]);
        end
        cur  <= vmax;
        prev <= cur;    // even column of the pair
        for (int m = 0; m < OUT_LANES; m++)
        begin
            if (layer1 || m < SMALL_LANES)
                res_word[m] <= max_pix(cur[m], prev[m]);
            else
                res_word[m] <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pair_rdy    <= 1'b0;
            last_s4     <= 1'b0;
            res_valid_p <= 1'b0;
            last_s5     <= 1'b0;
            pool_end_p  <= 1'b0;
        end
        else
        begin
            pair_rdy    <= v_odd;
            last_s4     <= v_last;
            res_valid_p <= pair_rdy;
            last_s5     <= last_s4;
            pool_end_p  <= last_s5;   // one cycle after the last result
        end
    end

    // bypass passes the low lanes straight through
    assign res_valid = pool_en ? res_valid_p : valid_in;
    assign res_data  = pool_en ? res_word : data_in[OUT_LANES-1:0];
    assign pool_end  = pool_en ? pool_end_p : nopool_end;

    col_even_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid_in |-> (col[0] == 1'b0 && col >= 2));

    res_spacing_a: assert property (@(posedge clk) disable iff (!rst_n)
        (pool_en && res_valid_p) |=> !res_valid_p);

endmodule

`default_nettype wire

//--- rtl/result_writer.sv
`timescale 1ns/1ps
`default_nettype none

module result_writer import cnn_pkg::*; #(
    parameter int DEPTH  = 64,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              res_valid,
    input  pool_word_t        res_data,
    input  logic              w_gnt,
    output logic              w_req,
    output logic [ADDR_W-1:0] w_addr,
    output pool_word_t        w_data,
    output logic [ADDR_W-1:0] wr_addr
);

    // pending slot, one entry
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            w_req <= 1'b0;
        else if (res_valid)
            w_req <= 1'b1;
        else if (w_gnt)
            w_req <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (res_valid)
            w_data <= res_data;
    end

    // next write address, wraps at DEPTH
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wr_addr <= '0;
        else if (w_req && w_gnt)
            wr_addr <= (wr_addr == ADDR_W'(DEPTH - 1)) ? '0 : wr_addr + 1'b1;
    end

    assign w_addr = wr_addr;

    slot_free_a: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> !(w_req && !w_gnt));

endmodule

`default_nettype wire

//--- tb/tb_pool_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pool_subsystem import cnn_pkg::*; ();

    localparam int DEPTH  = 64;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int SEED   = 5;
    localparam int TIMEOUT_CYCLES = 2000;   // the tests take roughly 450 cycles
    localparam int END_WAIT       = 20;     // cycles to wait for pool_end

    typedef logic [ADDR_W-1:0] addr_t;

    logic       clk;
    logic       rst_n;
    logic       pool_en;
    logic       layer1;
    logic [COL_W-1:0] col;
    logic       valid_in;
    in_col_t    data_in;
    logic       rd_req;
    addr_t      rd_addr;
    logic       rd_valid;
    pool_word_t rd_data;
    logic       pool_end;
    addr_t      wr_addr;

    pool_word_t model_mem [DEPTH];  // expected RAM contents
    addr_t      exp_addr;           // expected writer address
    logic [31:0] rng_state;
    string      cur_test;

    // host read bookkeeping
    addr_t      rq_addr[$];
    pool_word_t rq_exp[$];
    logic       rd_busy;
    addr_t      rd_cur_addr;
    pool_word_t rd_exp;
    int         rd_age;

    int         pe_total;
    logic       pe_now;
    int         cycle_count;
    int         data_errs;
    int         addr_errs;
    int         count_errs;
    int         plain_errs;

    pool_subsystem #(.DEPTH(DEPTH)) i_pool_subsystem (
        .clk      (clk),
        .rst_n    (rst_n),
        .pool_en  (pool_en),
        .layer1   (layer1),
        .col      (col),
        .valid_in (valid_in),
        .data_in  (data_in),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .pool_end (pool_end),
        .wr_addr  (wr_addr)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic pix_t max4(input pix_t a, input pix_t b, input pix_t c, input pix_t d);
        pix_t m;
        m = a;
        if (b > m)
            m = b;
        if (c > m)
            m = c;
        if (d > m)
            m = d;
        return m;
    endfunction

    task automatic check_word(input string name, input pool_word_t exp, input pool_word_t act);
        if (act !== exp)
        begin
            data_errs++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
        begin
            addr_errs++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            count_errs++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic next_column(output in_col_t c);
        logic [IN_LANES*PIX_W-1:0] flat;
        for (int k = 0; k < IN_LANES * PIX_W / 32; k++)
        begin
            rng_state = xorshift(rng_state);
            flat[32*k +: 32] = rng_state;
        end
        c = flat;
    endtask

    task automatic store_word(input pool_word_t w);
        model_mem[exp_addr] = w;
        exp_addr = addr_t'((int'(exp_addr) + 1) % DEPTH);
    endtask

    // checks a returned read and issues the next queued one
    task automatic host_step();
        if (rd_valid)
        begin
            if (rd_busy)
            begin
                check_word($sformatf("%s read %0d", cur_test, rd_cur_addr), rd_exp, rd_data);
                rd_busy = 1'b0;
            end
            else
            begin
                plain_errs++;
                $display("%s: rd_valid pulsed with no read outstanding", cur_test);
            end
        end
        else if (rd_busy)
        begin
            rd_age++;
            if (rd_age > 8)
            begin
                plain_errs++;
                $display("%s: rd_valid never came for address %0d", cur_test, rd_cur_addr);
                rd_busy = 1'b0;
            end
        end
        if (!rd_busy && rq_addr.size() > 0)
        begin
            rd_req      = 1'b1;
            rd_cur_addr = rq_addr.pop_front();
            rd_exp      = rq_exp.pop_front();
            rd_addr     = rd_cur_addr;
            rd_busy     = 1'b1;
            rd_age      = 0;
        end
        else
        begin
            rd_req = 1'b0;
        end
    endtask

    // sample outputs at the falling edge before driving
    task automatic step_cycle();
        @(negedge clk);
        pe_now = pool_end;
        if (pool_end)
            pe_total++;
        host_step();
    endtask

    task automatic queue_reads(input addr_t start, input int n);
        addr_t a;
        for (int i = 0; i < n; i++)
        begin
            a = start + addr_t'(i);
            rq_addr.push_back(a);
            rq_exp.push_back(model_mem[a]);
        end
    endtask

    task automatic drain_reads(input int limit);
        int n;
        n = 0;
        while ((rq_addr.size() > 0 || rd_busy) && n < limit)
        begin
            step_cycle();
            n++;
        end
        if (rq_addr.size() > 0 || rd_busy)
        begin
            plain_errs++;
            $display("%s: host reads did not finish within %0d cycles", cur_test, limit);
        end
    endtask

    task automatic read_back(input addr_t start, input int n);
        queue_reads(start, n);
        drain_reads(n * 6 + 10);
    endtask

    task automatic run_frame(input logic pen, input logic l1, input int ncols);
        in_col_t    cols[$];
        in_col_t    c;
        in_col_t    even_c;
        in_col_t    odd_c;
        pool_word_t word;
        int         k;
        int         pe_start;
        int         max_wait;
        logic       found;
        addr_t      gap;
        for (int i = 0; i < ncols; i++)
        begin
            next_column(c);
            cols.push_back(c);
        end
        if (pen)
        begin
            for (int j = 0; j < ncols / 2; j++)
            begin
                even_c = cols[2*j];
                odd_c  = cols[2*j+1];
                for (int m = 0; m < OUT_LANES; m++)
                begin
                    if (l1 || m < SMALL_LANES)
                        word[m] = max4(even_c[2*m], even_c[2*m+1], odd_c[2*m], odd_c[2*m+1]);
                    else
                        word[m] = '0;
                end
                store_word(word);
            end
        end
        else
        begin
            for (int i = 0; i < ncols; i++)
            begin
                c = cols[i];
                for (int m = 0; m < OUT_LANES; m++)
                    word[m] = c[m];
                store_word(word);
            end
        end

        step_cycle();
        pool_en  = pen;
        layer1   = l1;
        col      = COL_W'(ncols);
        pe_start = pe_total;
        for (int i = 0; i < ncols; i++)
        begin
            step_cycle();
            valid_in = 1'b1;
            data_in  = cols[i];
        end
        step_cycle();
        valid_in = 1'b0;
        data_in  = '0;

        k     = 0;
        found = 1'b0;
        while (!found && k < END_WAIT)
        begin
            step_cycle();
            k++;
            found = pe_now;
        end
        max_wait = pen ? 7 : 1;     // bypass flags the end right away
        if (!found)
        begin
            plain_errs++;
            $display("%s: no pool_end within %0d cycles of the frame end", cur_test, END_WAIT);
        end
        else
        begin
            if (k > max_wait)
            begin
                count_errs++;
                $display("[FAIL] %s frame_end: expected delay <= %0d, actual %0d",
                         cur_test, max_wait, k);
            end
            gap = exp_addr - wr_addr;
            if (gap > addr_t'(1))
            begin
                plain_errs++;
                $display("%s: pool_end came before the frame's writes were done", cur_test);
            end
        end
        step_cycle();
        check_addr({cur_test, " frame_end wr_addr"}, exp_addr, wr_addr);
        repeat (8)
            step_cycle();
        check_count({cur_test, " pool_end pulses"}, 1, pe_total - pe_start);
    endtask

    task automatic test_pooled(input string name, input logic l1);
        addr_t start;
        cur_test = name;
        start    = exp_addr;
        run_frame(1'b1, l1, 16);
        check_addr({name, " wr_addr"}, start + addr_t'(8), wr_addr);
        read_back(start, 8);
    endtask

    task automatic test_bypass();
        addr_t start;
        cur_test = "bypass";
        start    = exp_addr;
        run_frame(1'b0, 1'b0, 8);
        check_addr("bypass wr_addr", start + addr_t'(8), wr_addr);
        read_back(start, 8);
    endtask

    task automatic test_read_during_write();
        addr_t start;
        cur_test = "read_during_write";
        start    = exp_addr;
        queue_reads(addr_t'(0), 8);     // words of the first frame
        run_frame(1'b1, 1'b1, 16);
        drain_reads(40);
        check_addr("read_during_write wr_addr", start + addr_t'(8), wr_addr);
        read_back(start, 8);
    endtask

    task automatic test_address_wrap();
        addr_t start;
        cur_test = "address_wrap";
        start    = exp_addr;
        run_frame(1'b1, 1'b1, 32);
        run_frame(1'b1, 1'b0, 32);
        run_frame(1'b0, 1'b1, 16);
        check_addr("address_wrap wr_addr", start + addr_t'(48), wr_addr);
        check_addr("address_wrap model", exp_addr, wr_addr);
        read_back(addr_t'(0), 16);      // overwritten after the wrap
        read_back(addr_t'(48), 16);
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        pool_en     = 1'b0;
        layer1      = 1'b0;
        col         = COL_W'(2);
        valid_in    = 1'b0;
        data_in     = '0;
        rd_req      = 1'b0;
        rd_addr     = '0;
        rng_state   = 32'(SEED);
        exp_addr    = '0;
        rd_busy     = 1'b0;
        rd_cur_addr = '0;
        rd_exp      = '0;
        rd_age      = 0;
        pe_total    = 0;
        pe_now      = 1'b0;
        cycle_count = 0;
        data_errs   = 0;
        addr_errs   = 0;
        count_errs  = 0;
        plain_errs  = 0;
        cur_test    = "reset";

        repeat (3)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        step_cycle();
        check_addr("reset wr_addr", '0, wr_addr);
        if (rd_valid !== 1'b0 || pool_end !== 1'b0)
        begin
            plain_errs++;
            $display("reset: rd_valid or pool_end is not low after reset");
        end

        test_pooled("pooled_layer1", 1'b1);
        test_pooled("pooled_small", 1'b0);
        test_bypass();
        test_read_during_write();
        test_address_wrap();

        $display("errors: data %0d, address %0d, count %0d, other %0d",
                 data_errs, addr_errs, count_errs, plain_errs);
        if (data_errs + addr_errs + count_errs + plain_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
